// File: exu_alu.f
hdl/exu_alu_pkg.sv
hdl/alu_rglr.sv
hdl/alu_bjp.sv
hdl/alu_dpath.sv
hdl/alu_result_arb.sv
hdl/exu_alu.sv
tests/exu_alu_properties.sv
tests/tb_exu_alu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_exu_alu
FILELIST  = exu_alu.f
SIM       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: tests/tb_exu_alu.sv
// Testbench for the integer execute stage
// Random ALU, branch, jump, exception and system instructions under random back-pressure
`timescale 1ns/1ps

module tb_exu_alu;
  import exu_alu_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;   // 108 instructions, ~4 cycles each, wide margin

  typedef struct packed {
    cmt_t  cmt;
    wbck_t wbck;
    logic  need;
  } expect_t;

  logic        clk;
  logic        i_rst_n;
  logic        i_valid;
  logic        o_ready;
  issue_t      i_issue;
  logic        o_cmt_valid;
  logic        i_cmt_ready;
  cmt_t        o_cmt;
  logic        o_wbck_valid;
  logic        i_wbck_ready;
  wbck_t       o_wbck;
  logic [31:0] lfsr_state;
  expect_t     exp_cur;
  string       test_name;
  int          n_issued;
  int          n_commits;
  int          cycles;

  exu_alu dut0 (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////
  // Reference model

  function automatic expect_t expected_result(input issue_t is);
    expect_t         e;
    alu_info_t       a;
    bjp_info_t       b;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    logic            excp;
    logic            is_alu;
    logic            is_bjp;
    logic            taken;
    logic            err;
    a      = is.info.alu;
    b      = is.info.bjp;
    excp   = is.ilegl | is.buserr | is.misalgn;
    is_alu = ~excp & (a.grp == GRP_ALU);
    is_bjp = ~excp & (a.grp == GRP_BJP);
    x      = a.op1pc ? is.pc : is.rs1;
    y      = a.op2imm ? is.imm : is.rs2;
    e      = '0;
    err    = ~is_alu & ~is_bjp;   // Exceptions and OTHER
    taken  = 1'b0;
    if (is_alu) begin
      err = a.ecall | a.ebreak | a.wfi;
      case (1'b1)
        a.op_sub:  e.wbck.wdat = x - y;
        a.op_xor:  e.wbck.wdat = x ^ y;
        a.op_sll:  e.wbck.wdat = x << y[4:0];
        a.op_srl:  e.wbck.wdat = x >> y[4:0];
        a.op_sra:  e.wbck.wdat = $signed(x) >>> y[4:0];
        a.op_or:   e.wbck.wdat = x | y;
        a.op_and:  e.wbck.wdat = x & y;
        a.op_slt:  e.wbck.wdat = {31'd0, $signed(x) < $signed(y)};
        a.op_sltu: e.wbck.wdat = {31'd0, x < y};
        a.op_lui:  e.wbck.wdat = y;
        default:   e.wbck.wdat = x + y;
      endcase
    end
    if (is_bjp) begin
      e.wbck.wdat = is.pc + (b.rv32 ? 32'd4 : 32'd2);   // Link address
      taken = b.jump | (b.beq & (is.rs1 == is.rs2)) | (b.bne & (is.rs1 != is.rs2))
            | (b.blt & ($signed(is.rs1) < $signed(is.rs2)))
            | (b.bge & ($signed(is.rs1) >= $signed(is.rs2)))
            | (b.bltu & (is.rs1 < is.rs2)) | (b.bgeu & (is.rs1 >= is.rs2));
    end
    e.cmt.pc          = is.pc;
    e.cmt.rv32        = a.rv32;
    e.cmt.bjp         = is_bjp;
    e.cmt.bjp_prdt    = is_bjp & b.bprdt;
    e.cmt.bjp_rslv    = is_bjp & taken;
    e.cmt.ecall       = is_alu & a.ecall;
    e.cmt.ebreak      = is_alu & a.ebreak;
    e.cmt.wfi         = is_alu & a.wfi;
    e.cmt.ifu_ilegl   = is.ilegl | (~excp & ~is_alu & ~is_bjp);
    e.cmt.ifu_buserr  = is.buserr;
    e.cmt.ifu_misalgn = is.misalgn;
    e.wbck.rdidx      = is.rdidx;
    e.need            = is.rdwen & ~err;
    return e;
  endfunction

  ////////////////////
  // Checks

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s expected %0b actual %0b", name, exp, act));
    end
  endtask

  task automatic check_cmt(input string name, input cmt_t exp, input cmt_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s commit expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_wbck(input string name, input wbck_t exp, input wbck_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s write-back expected %h actual %h", name, exp, act));
    end
  endtask

  // Handshake and payload compare on every rising edge
  always @(posedge clk) begin
    if (i_rst_n && !i_valid) begin
      check_flag("idle cmt_valid", 1'b0, o_cmt_valid);
      check_flag("idle wbck_valid", 1'b0, o_wbck_valid);
    end else if (i_rst_n) begin
      check_flag({test_name, " cmt_valid"}, i_wbck_ready | ~exp_cur.need, o_cmt_valid);
      check_flag({test_name, " wbck_valid"}, exp_cur.need & i_cmt_ready, o_wbck_valid);
      check_flag({test_name, " ready"}, i_cmt_ready & (i_wbck_ready | ~exp_cur.need), o_ready);
      if (o_cmt_valid && i_cmt_ready) begin
        n_commits++;
        check_cmt(test_name, exp_cur.cmt, o_cmt);
        if (exp_cur.need) begin
          check_wbck(test_name, exp_cur.wbck, o_wbck);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_now($sformatf("Timeout, run not finished after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  ////////////////////
  // Stimulus

  task automatic rand_issue(output issue_t is);
    logic [31:0] bits;
    is = '0;
    take_bits(32, is.rs1);
    take_bits(32, is.rs2);
    take_bits(32, is.imm);
    take_bits(32, is.pc);
    take_bits(5, bits);
    is.rdidx = bits[4:0];
    is.rdwen = 1'b1;
  endtask

  // Holds the instruction until o_ready, with new random readies each cycle
  task automatic issue_one(input string name, input issue_t is);
    logic [31:0] bits;
    logic        done;
    @(negedge clk);
    take_bits(2, bits);
    if (bits[1:0] == 2'b00) begin   // Idle gap now and then
      i_valid = 1'b0;
      @(negedge clk);
    end
    test_name = name;
    i_issue   = is;
    exp_cur   = expected_result(is);
    i_valid   = 1'b1;
    n_issued++;
    done = 1'b0;
    while (!done) begin
      take_bits(2, bits);
      i_cmt_ready  = bits[0];
      i_wbck_ready = bits[1];
      @(posedge clk);
      done = o_ready;
      if (!done) begin
        @(negedge clk);
      end
    end
  endtask

  initial begin
    issue_t      is;
    alu_info_t   a;
    bjp_info_t   b;
    logic [31:0] bits;
    clk          = 1'b0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_issue      = '0;
    i_cmt_ready  = 1'b0;
    i_wbck_ready = 1'b0;
    lfsr_state   = 32'h7e967e4f;
    exp_cur      = '0;
    test_name    = "reset";
    n_issued     = 0;
    n_commits    = 0;
    cycles       = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    for (int i = 0; i < 60; i++) begin   // Register and immediate ALU ops
      rand_issue(is);
      take_bits(6, bits);
      a        = '0;
      a.grp    = GRP_ALU;
      a.rv32   = 1'b1;
      a.op2imm = bits[4];
      a.op1pc  = bits[5];
      {a.op_add, a.op_sub, a.op_xor, a.op_sll, a.op_srl, a.op_sra, a.op_or, a.op_and,
       a.op_slt, a.op_sltu, a.op_lui} = 11'b1 << (int'(bits[3:0]) % 11);
      is.rdwen    = (i % 8 != 0);
      is.info.alu = a;
      issue_one("alu", is);
    end

    for (int i = 0; i < 24; i++) begin   // Every branch kind, equal operands half the time
      rand_issue(is);
      take_bits(2, bits);
      b       = '0;
      b.grp   = GRP_BJP;
      b.rv32  = bits[0];
      b.bprdt = bits[1];
      {b.beq, b.bne, b.blt, b.bge, b.bltu, b.bgeu} = 6'b1 << (i % 6);
      if (i % 12 < 6) begin
        is.rs2 = is.rs1;
      end
      is.rdwen    = 1'b0;
      is.info.bjp = b;
      issue_one("branch", is);
    end

    for (int i = 0; i < 8; i++) begin
      rand_issue(is);
      b           = '0;
      b.grp       = GRP_BJP;
      b.rv32      = i[0];
      b.bprdt     = i[1];
      b.jump      = 1'b1;
      is.info.bjp = b;
      issue_one("jump", is);
    end

    for (int i = 0; i < 10; i++) begin   // Fetch exceptions, then OTHER group
      rand_issue(is);
      take_bits(3, bits);
      a        = '0;
      a.rv32   = bits[2];
      a.op_add = 1'b1;
      if (i < 8) begin
        a.grp = decinfo_grp_e'(bits[1:0]);
        {is.ilegl, is.buserr, is.misalgn} = 3'(i % 7 + 1);
      end else begin
        a.grp = decinfo_grp_e'(2'(i - 6));   // OTHER and the spare encoding
      end
      is.info.alu = a;
      issue_one("fetch_excp", is);
    end

    for (int i = 0; i < 6; i++) begin
      rand_issue(is);
      a        = '0;
      a.grp    = GRP_ALU;
      a.rv32   = 1'b1;
      a.op_add = 1'b1;
      {a.ecall, a.ebreak, a.wfi} = 3'b100 >> (i % 3);
      is.info.alu = a;
      issue_one("system", is);
    end

    @(negedge clk);
    i_valid = 1'b0;
    repeat (2) @(posedge clk);
    if (n_commits == n_issued) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_now($sformatf("CHECK FAILED commit_count expected %0d actual %0d",
                         n_issued, n_commits));
    end
  end

endmodule

// File: tests/exu_alu_properties.sv
// Handshake assertions for the execute stage, bound to the top level
`timescale 1ns/1ps

module exu_alu_properties (
  input logic clk,
  input logic i_rst_n,
  input logic i_valid,
  input logic o_ready,
  input logic o_cmt_valid,
  input logic i_cmt_ready,
  input logic o_wbck_valid,
  input logic i_wbck_ready
);

  // Write-back only moves together with its commit
  wbck_with_cmt: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_wbck_valid && i_wbck_ready) |-> (o_cmt_valid && i_cmt_ready))
    else $error("write-back transfer without a commit transfer");

  wbck_needs_cmt_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wbck_valid |-> i_cmt_ready)
    else $error("write-back valid while commit not ready");

  no_valid_when_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
    !i_valid |-> (!o_cmt_valid && !o_wbck_valid))
    else $error("output valid without an instruction");

  // Accepted instruction always commits in that cycle
  ready_means_commit: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_valid && o_ready) |-> (o_cmt_valid && i_cmt_ready))
    else $error("instruction accepted without commit");

endmodule

bind exu_alu exu_alu_properties props0 (
  .clk          (clk),
  .i_rst_n      (i_rst_n),
  .i_valid      (i_valid),
  .o_ready      (o_ready),
  .o_cmt_valid  (o_cmt_valid),
  .i_cmt_ready  (i_cmt_ready),
  .o_wbck_valid (o_wbck_valid),
  .i_wbck_ready (i_wbck_ready)
);

// File: hdl/exu_alu.sv
// Integer execute stage top
// Group decode and wiring of the ALU, branch unit, shared datapath and arbiter
`timescale 1ns/1ps

module exu_alu (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_valid,
  output logic                o_ready,
  input  exu_alu_pkg::issue_t i_issue,
  output logic                o_cmt_valid,
  input  logic                i_cmt_ready,
  output exu_alu_pkg::cmt_t   o_cmt,
  output logic                o_wbck_valid,
  input  logic                i_wbck_ready,
  output exu_alu_pkg::wbck_t  o_wbck
);
  import exu_alu_pkg::*;

  decinfo_grp_e    grp;
  logic            ifu_excp;
  logic            excp_sel;
  logic            alu_sel;
  logic            bjp_sel;
  logic            alu_req;
  dpath_req_t      alu_dreq;
  dpath_req_t      bjp_dreq;
  logic [XLEN-1:0] dpath_res;
  logic            dpath_cmp;
  unit_rsp_t       alu_rsp;
  unit_rsp_t       bjp_rsp;
  logic            ecall;
  logic            ebreak;
  logic            wfi;
  logic            bjp_prdt;
  logic            bjp_rslv;

  ////////////////////
  // Group decode

  assign grp      = i_issue.info.alu.grp;
  assign ifu_excp = i_issue.ilegl | i_issue.buserr | i_issue.misalgn;
  assign excp_sel = ifu_excp | ~(grp inside {GRP_ALU, GRP_BJP});
  assign alu_sel  = ~excp_sel & (grp == GRP_ALU);
  assign bjp_sel  = ~excp_sel & (grp == GRP_BJP);
  assign alu_req  = alu_sel & i_issue.rdwen;   // Datapath only needed for a write-back

  alu_rglr u_rglr (
    .i_issue (i_issue),   .o_req  (alu_dreq), .i_res   (dpath_res),
    .o_rsp   (alu_rsp),   .o_ecall(ecall),    .o_ebreak(ebreak),
    .o_wfi   (wfi)
  );

  alu_bjp u_bjp (
    .i_issue (i_issue),   .o_req  (bjp_dreq), .i_res   (dpath_res),
    .i_cmp   (dpath_cmp), .o_rsp  (bjp_rsp),  .o_prdt  (bjp_prdt),
    .o_rslv  (bjp_rslv)
  );

  alu_dpath u_dpath (
    .i_alu_req (alu_req),   .i_alu (alu_dreq), .i_bjp (bjp_dreq),
    .o_res     (dpath_res), .o_cmp (dpath_cmp)
  );

  alu_result_arb u_arb (
    .i_valid      (i_valid),      .o_ready      (o_ready),
    .i_issue      (i_issue),      .i_alu_sel    (alu_sel),
    .i_bjp_sel    (bjp_sel),      .i_alu_rsp    (alu_rsp),
    .i_bjp_rsp    (bjp_rsp),      .i_ecall      (ecall),
    .i_ebreak     (ebreak),       .i_wfi        (wfi),
    .i_bjp_prdt   (bjp_prdt),     .i_bjp_rslv   (bjp_rslv),
    .o_cmt_valid  (o_cmt_valid),  .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),        .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready), .o_wbck       (o_wbck)
  );

endmodule

// File: hdl/alu_result_arb.sv
// Result arbiter
// Picks the unit response and splits it into commit and write-back handshakes
`timescale 1ns/1ps

module alu_result_arb (
  input  logic                   i_valid,
  output logic                   o_ready,
  input  exu_alu_pkg::issue_t    i_issue,
  input  logic                   i_alu_sel,
  input  logic                   i_bjp_sel,
  input  exu_alu_pkg::unit_rsp_t i_alu_rsp,
  input  exu_alu_pkg::unit_rsp_t i_bjp_rsp,
  input  logic                   i_ecall,
  input  logic                   i_ebreak,
  input  logic                   i_wfi,
  input  logic                   i_bjp_prdt,
  input  logic                   i_bjp_rslv,
  output logic                   o_cmt_valid,
  input  logic                   i_cmt_ready,
  output exu_alu_pkg::cmt_t      o_cmt,
  output logic                   o_wbck_valid,
  input  logic                   i_wbck_ready,
  output exu_alu_pkg::wbck_t     o_wbck
);
  import exu_alu_pkg::*;

  unit_rsp_t rsp;
  logic      fetch_excp;
  logic      grp_other;
  logic      need_wbck;

  assign fetch_excp = i_issue.ilegl | i_issue.buserr | i_issue.misalgn;
  assign grp_other  = ~i_alu_sel & ~i_bjp_sel & ~fetch_excp;

  always_comb begin
    if (i_alu_sel) begin
      rsp = i_alu_rsp;
    end else if (i_bjp_sel) begin
      rsp = i_bjp_rsp;
    end else begin
      rsp.wdat = '0;   // Exception path
      rsp.err  = 1'b1;
    end
  end

  ////////////////////
  // Handshakes

  assign need_wbck = i_issue.rdwen & ~rsp.err;

  // Commit and write-back go together or not at all
  assign o_cmt_valid  = i_valid & (i_wbck_ready | ~need_wbck);
  assign o_wbck_valid = i_valid & need_wbck & i_cmt_ready;
  assign o_ready      = i_cmt_ready & (i_wbck_ready | ~need_wbck);

  ////////////////////
  // Payloads

  assign o_wbck.wdat  = rsp.wdat;
  assign o_wbck.rdidx = i_issue.rdidx;

  assign o_cmt.pc          = i_issue.pc;
  assign o_cmt.rv32        = i_issue.info.alu.rv32;
  assign o_cmt.bjp         = i_bjp_sel;
  assign o_cmt.bjp_prdt    = i_bjp_sel & i_bjp_prdt;
  assign o_cmt.bjp_rslv    = i_bjp_sel & i_bjp_rslv;
  assign o_cmt.ecall       = i_alu_sel & i_ecall;
  assign o_cmt.ebreak      = i_alu_sel & i_ebreak;
  assign o_cmt.wfi         = i_alu_sel & i_wfi;
  assign o_cmt.ifu_ilegl   = i_issue.ilegl | grp_other;   // Unknown group is illegal
  assign o_cmt.ifu_buserr  = i_issue.buserr;
  assign o_cmt.ifu_misalgn = i_issue.misalgn;

endmodule

// File: hdl/alu_dpath.sv
// Shared ALU datapath
// One adder, one barrel shifter, logic ops and comparator for both requesters
`timescale 1ns/1ps

module alu_dpath (
  input  logic                         i_alu_req,
  input  exu_alu_pkg::dpath_req_t      i_alu,
  input  exu_alu_pkg::dpath_req_t      i_bjp,
  output logic [exu_alu_pkg::XLEN-1:0] o_res,
  output logic                         o_cmp
);
  import exu_alu_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  dpath_req_t         req;
  logic               is_sub;
  logic               is_unsigned;
  logic               is_sll;
  logic [XLEN:0]      add_op1;
  logic [XLEN:0]      add_op2;
  logic [XLEN:0]      add_res;
  logic               lt;
  logic               eq;
  logic [XLEN-1:0]    xor_res;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    op1_rev;
  logic [XLEN-1:0]    sh_in;
  logic [XLEN-1:0]    sh_out;
  logic [XLEN-1:0]    sll_res;
  logic [XLEN-1:0]    sra_fill;

  // ALU wins only when it has something to write back
  assign req = i_alu_req ? i_alu : i_bjp;

  ////////////////////
  // Adder / subtractor

  assign is_sub      = req.op inside {OP_SUB, OP_SLT, OP_SLTU, OP_LT, OP_GE, OP_LTU, OP_GEU};
  assign is_unsigned = req.op inside {OP_SLTU, OP_LTU, OP_GEU};

  // One extra bit, sign or zero extended, gives the less-than flag
  assign add_op1 = {~is_unsigned & req.op1[XLEN-1], req.op1};
  assign add_op2 = {~is_unsigned & req.op2[XLEN-1], req.op2};
  assign add_res = add_op1 + (is_sub ? ~add_op2 : add_op2) + {{XLEN{1'b0}}, is_sub};

  assign lt      = add_res[XLEN];
  assign xor_res = req.op1 ^ req.op2;
  assign eq      = (xor_res == '0);

  ////////////////////
  // Barrel shifter

  // Left shifts run through the right shifter on reversed bits
  assign is_sll   = (req.op == OP_SLL);
  assign shamt    = req.op2[SHAMT_W-1:0];
  assign op1_rev  = {<<{req.op1}};
  assign sh_in    = is_sll ? op1_rev : req.op1;
  assign sh_out   = sh_in >> shamt;
  assign sll_res  = {<<{sh_out}};
  assign sra_fill = ~({XLEN{1'b1}} >> shamt) & {XLEN{req.op1[XLEN-1]}};

  ////////////////////
  // Result select

  always_comb begin
    case (req.op)
      OP_EQ:          o_cmp = eq;
      OP_NE:          o_cmp = ~eq;
      OP_LT, OP_LTU:  o_cmp = lt;
      OP_GE, OP_GEU:  o_cmp = ~lt;
      default:        o_cmp = 1'b0;
    endcase
  end

  always_comb begin
    case (req.op)
      OP_ADD, OP_SUB:  o_res = add_res[XLEN-1:0];
      OP_XOR:          o_res = xor_res;
      OP_SLL:          o_res = sll_res;
      OP_SRL:          o_res = sh_out;
      OP_SRA:          o_res = sh_out | sra_fill;
      OP_OR:           o_res = req.op1 | req.op2;
      OP_AND:          o_res = req.op1 & req.op2;
      OP_SLT, OP_SLTU: o_res = {{(XLEN-1){1'b0}}, lt};
      OP_LUI:          o_res = req.op2;   // Immediate already shifted
      default:         o_res = {{(XLEN-1){1'b0}}, o_cmp};
    endcase
  end

endmodule

// File: hdl/alu_bjp.sv
// Branch and jump unit
// Requests the compare or link add and resolves the taken flag
`timescale 1ns/1ps

module alu_bjp (
  input  exu_alu_pkg::issue_t          i_issue,
  output exu_alu_pkg::dpath_req_t      o_req,
  input  logic [exu_alu_pkg::XLEN-1:0] i_res,
  input  logic                         i_cmp,
  output exu_alu_pkg::unit_rsp_t       o_rsp,
  output logic                         o_prdt,
  output logic                         o_rslv
);
  import exu_alu_pkg::*;

  bjp_info_t       info;
  logic [XLEN-1:0] link_inc;

  assign info     = i_issue.info.bjp;
  assign link_inc = info.rv32 ? XLEN'(4) : XLEN'(2);   // Compressed jumps step by 2

  ////////////////////
  // Datapath request

  always_comb begin
    o_req.op1 = i_issue.rs1;
    o_req.op2 = i_issue.rs2;
    if (info.jump) begin
      o_req.op1 = i_issue.pc;
      o_req.op2 = link_inc;
      o_req.op  = OP_ADD;
    end else if (info.bne) begin
      o_req.op = OP_NE;
    end else if (info.blt) begin
      o_req.op = OP_LT;
    end else if (info.bge) begin
      o_req.op = OP_GE;
    end else if (info.bltu) begin
      o_req.op = OP_LTU;
    end else if (info.bgeu) begin
      o_req.op = OP_GEU;
    end else begin
      o_req.op = OP_EQ;   // beq
    end
  end

  ////////////////////
  // Resolution

  // Jumps are always taken, the compare bit is low for them
  assign o_rslv = info.jump | i_cmp;
  assign o_prdt = info.bprdt;

  // Link address, written only when rdwen is set
  assign o_rsp.wdat = i_res;
  assign o_rsp.err  = 1'b0;

endmodule

// File: hdl/alu_rglr.sv
// Regular ALU unit
// Turns ALU decode info into a datapath request and flags system instructions
`timescale 1ns/1ps

module alu_rglr (
  input  exu_alu_pkg::issue_t          i_issue,
  output exu_alu_pkg::dpath_req_t      o_req,
  input  logic [exu_alu_pkg::XLEN-1:0] i_res,
  output exu_alu_pkg::unit_rsp_t       o_rsp,
  output logic                         o_ecall,
  output logic                         o_ebreak,
  output logic                         o_wfi
);
  import exu_alu_pkg::*;

  alu_info_t info;

  assign info = i_issue.info.alu;

  // Operand muxes
  assign o_req.op1 = info.op1pc  ? i_issue.pc  : i_issue.rs1;
  assign o_req.op2 = info.op2imm ? i_issue.imm : i_issue.rs2;

  // One-hot operation fields to enum
  always_comb begin
    if (info.op_sub) begin
      o_req.op = OP_SUB;
    end else if (info.op_xor) begin
      o_req.op = OP_XOR;
    end else if (info.op_sll) begin
      o_req.op = OP_SLL;
    end else if (info.op_srl) begin
      o_req.op = OP_SRL;
    end else if (info.op_sra) begin
      o_req.op = OP_SRA;
    end else if (info.op_or) begin
      o_req.op = OP_OR;
    end else if (info.op_and) begin
      o_req.op = OP_AND;
    end else if (info.op_slt) begin
      o_req.op = OP_SLT;
    end else if (info.op_sltu) begin
      o_req.op = OP_SLTU;
    end else if (info.op_lui) begin
      o_req.op = OP_LUI;
    end else begin
      o_req.op = OP_ADD;   // op_add, and nop
    end
  end

  assign o_ecall  = info.ecall;
  assign o_ebreak = info.ebreak;
  assign o_wfi    = info.wfi;

  // System instructions never write rd
  assign o_rsp.wdat = i_res;
  assign o_rsp.err  = info.ecall | info.ebreak | info.wfi;

endmodule

// File: hdl/exu_alu_pkg.sv
// Execute stage shared definitions
// Widths, decode-info union, datapath operations and handshake payloads
package exu_alu_pkg;

  localparam int XLEN      = 32;
  localparam int RFIDX_W   = 5;
  localparam int DECINFO_W = 19;

  // Instruction group, encoding 3 also decodes as OTHER
  typedef enum logic [1:0] {
    GRP_ALU   = 2'd0,
    GRP_BJP   = 2'd1,
    GRP_OTHER = 2'd2
  } decinfo_grp_e;

  ////////////////////
  // Decode-info views

  typedef struct packed {
    decinfo_grp_e grp;
    logic         rv32;
    logic         op_add;
    logic         op_sub;
    logic         op_xor;
    logic         op_sll;
    logic         op_srl;
    logic         op_sra;
    logic         op_or;
    logic         op_and;
    logic         op_slt;
    logic         op_sltu;
    logic         op_lui;
    logic         op2imm;   // Operand 2 from immediate
    logic         op1pc;    // Operand 1 from pc (auipc)
    logic         ecall;
    logic         ebreak;
    logic         wfi;
  } alu_info_t;

  typedef struct packed {
    decinfo_grp_e          grp;
    logic                  rv32;
    logic                  jump;
    logic                  beq;
    logic                  bne;
    logic                  blt;
    logic                  bge;
    logic                  bltu;
    logic                  bgeu;
    logic                  bprdt;   // Predicted taken at fetch
    logic [DECINFO_W-12:0] rsvd;
  } bjp_info_t;

  // grp and rv32 share the top bits in both views
  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
  } decinfo_u;

  ////////////////////
  // Datapath request

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_SLT, OP_SLTU, OP_LUI,
    OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU
  } dpath_op_e;

  typedef struct packed {
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    dpath_op_e       op;
  } dpath_req_t;

  ////////////////////
  // Stage payloads

  typedef struct packed {
    logic [XLEN-1:0]    rs1;
    logic [XLEN-1:0]    rs2;
    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    pc;
    decinfo_u           info;
    logic [RFIDX_W-1:0] rdidx;
    logic               rdwen;
    logic               ilegl;    // Fetch exceptions
    logic               buserr;
    logic               misalgn;
  } issue_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            rv32;
    logic            bjp;
    logic            bjp_prdt;
    logic            bjp_rslv;
    logic            ecall;
    logic            ebreak;
    logic            wfi;
    logic            ifu_ilegl;
    logic            ifu_buserr;
    logic            ifu_misalgn;
  } cmt_t;

  typedef struct packed {
    logic [XLEN-1:0]    wdat;
    logic [RFIDX_W-1:0] rdidx;
  } wbck_t;

  typedef struct packed {
    logic [XLEN-1:0] wdat;
    logic            err;   // Blocks the write-back
  } unit_rsp_t;

endpackage
